// ==== logic/fetch_pkg.sv ====
/*
 * Shared types and constants for the instruction fetch front end.
 * Modules import this package inside their body and use scoped
 * names for typed ports in their headers.
 */

package fetch_pkg;

  ////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////

  // Byte address into instruction memory
  typedef logic [31:0] addr_t;

  // Memory word or one whole instruction
  typedef logic [31:0] instr_t;

  // Complete instructions held in the queue, 0 to 6
  typedef logic [2:0] instr_cnt_t;

  // Requests granted but not yet answered
  typedef logic [1:0] outst_cnt_t;

  // Responses still to throw away after a branch
  typedef logic [1:0] flush_cnt_t;

  ////////////////////////////////////////
  // Fetch constants
  ////////////////////////////////////////

  // Three words cover one straddling instruction plus two in flight
  localparam int unsigned FETCH_DEPTH = 3;
  localparam int unsigned MAX_OUTSTANDING = 2;

endpackage

// ==== logic/fetch_ctrl.sv ====
/*
 * Fetch control. Tracks requests in flight, discards responses from
 * the old path after a branch, and decides when a new word is fetched.
 * Drives the request strobe of the request generator and the gated
 * response strobe used by the alignment datapath.
 */

module fetch_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  branch_i,
  input  logic                  prefetch_en_i,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  fetch_pkg::instr_cnt_t instr_cnt_i,
  output logic                  fetch_valid_o,
  output logic                  resp_valid_gated_o,
  output logic                  prefetch_busy_o
);

  import fetch_pkg::*;

  outst_cnt_t outst_q;
  outst_cnt_t outst_n;
  flush_cnt_t flush_q;
  flush_cnt_t flush_n;
  logic       req_accept;

  ////////////////////////////////////////
  // Request decision
  ////////////////////////////////////////

  // Fetch when the queue runs dry, or on a branch, within the limit
  assign fetch_valid_o = prefetch_en_i &&
                         (outst_q < MAX_OUTSTANDING) &&
                         ((instr_cnt_i == 3'd0) ||
                          (instr_cnt_i == 3'd1 && outst_q == 2'd0) ||
                          branch_i);

  assign req_accept = fetch_valid_o && mem_gnt_i;

  // Busy while words are in flight or a request is raised
  assign prefetch_busy_o = (outst_q != 2'd0) || fetch_valid_o;

  // Old-path responses never reach the datapath
  assign resp_valid_gated_o = (flush_q != 2'd0) ? 1'b0 : mem_rvalid_i;

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  always_comb begin
    outst_n = outst_q;
    if (req_accept && !mem_rvalid_i) begin
      outst_n = outst_q + 2'd1;
    end else if (!req_accept && mem_rvalid_i) begin
      outst_n = outst_q - 2'd1;
    end
  end

  always_comb begin
    flush_n = flush_q;
    if (branch_i) begin
      // Everything in flight is stale, minus a word landing right now
      flush_n = mem_rvalid_i ? outst_q - 2'd1 : outst_q;
    end else if (mem_rvalid_i && flush_q != 2'd0) begin
      flush_n = flush_q - 2'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= '0;
      flush_q <= '0;
    end else begin
      outst_q <= outst_n;
      flush_q <= flush_n;
    end
  end

endmodule

// ==== logic/fetch_req_gen.sv ====
/*
 * Memory request generator. Holds the next aligned word address and
 * presents it with the request strobe until the memory grants it.
 * A branch redirects the request in the same cycle.
 */

module fetch_req_gen (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             fetch_valid_i,
  input  logic             mem_gnt_i,
  output logic             mem_req_o,
  output fetch_pkg::addr_t mem_addr_o
);

  import fetch_pkg::*;

  addr_t addr_q;
  addr_t addr_n;
  addr_t branch_word;

  // Memory is read in whole words only
  assign branch_word = {branch_addr_i[31:2], 2'b00};

  assign mem_req_o  = fetch_valid_i;
  assign mem_addr_o = branch_i ? branch_word : addr_q;

  always_comb begin
    addr_n = addr_q;
    if (branch_i) begin
      // Step past the target word only if it went out this cycle
      addr_n = (fetch_valid_i && mem_gnt_i) ? branch_word + 32'd4 : branch_word;
    end else if (fetch_valid_i && mem_gnt_i) begin
      addr_n = addr_q + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr_n;
    end
  end

endmodule

// ==== logic/instr_count_track.sv ====
/*
 * Counts complete instructions held in the alignment queue.
 * Follows the halfword alignment of the write side so each incoming
 * word adds zero, one or two instructions; each pop removes one.
 */

module instr_count_track (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  branch_i,
  input  fetch_pkg::addr_t      branch_addr_i,
  input  logic                  resp_valid_i,
  input  fetch_pkg::instr_t     resp_rdata_i,
  input  logic                  instr_pop_i,
  output fetch_pkg::instr_cnt_t instr_cnt_o
);

  import fetch_pkg::*;

  // Write side starts on a halfword boundary (aligned) with nothing pending
  logic       aligned_q, aligned_n;
  // Unaligned and complete only after a branch into an upper half
  logic       complete_q, complete_n;
  logic [1:0] n_incoming;
  logic       lower_counts;
  logic       upper_compressed;
  instr_cnt_t cnt_q;

  assign upper_compressed = resp_rdata_i[17:16] != 2'b11;
  // Lower half is skipped only right after an unaligned branch
  assign lower_counts = aligned_q || !complete_q;

  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = 2'd0;
    if (branch_i) begin
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_valid_i) begin
      if (aligned_q && resp_rdata_i[1:0] == 2'b11) begin
        // Whole word is one 32-bit instruction, state unchanged
        n_incoming = 2'd1;
      end else begin
        n_incoming = {1'b0, lower_counts} + {1'b0, upper_compressed};
        // An uncompressed upper half leaves a pending straddler
        aligned_n  = upper_compressed;
        complete_n = upper_compressed;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aligned_q  <= 1'b1;
      complete_q <= 1'b1;
      cnt_q      <= '0;
    end else begin
      aligned_q  <= aligned_n;
      complete_q <= complete_n;
      if (branch_i) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + instr_cnt_t'(n_incoming) - instr_cnt_t'(instr_pop_i);
      end
    end
  end

  assign instr_cnt_o = cnt_q;

endmodule

// ==== logic/instr_align_buf.sv ====
/*
 * Alignment buffer. Queues returned words in three entries and cuts
 * out whole 16-bit or 32-bit instructions for decode, together with
 * their addresses. A fresh response can feed the output directly.
 * Entry 0 is always the word holding the current instruction start.
 */

module instr_align_buf (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              branch_i,
  input  fetch_pkg::addr_t  branch_addr_i,
  input  logic              resp_valid_i,
  input  fetch_pkg::instr_t resp_rdata_i,
  input  logic              instr_ready_i,
  output logic              instr_valid_o,
  output fetch_pkg::instr_t instr_o,
  output fetch_pkg::addr_t  instr_addr_o,
  output logic              instr_pop_o
);

  import fetch_pkg::*;

  instr_t [0:FETCH_DEPTH-1] rdata_q, rdata_int, rdata_n;
  logic   [0:FETCH_DEPTH-1] valid_q, valid_int, valid_n;

  addr_t  addr_q, addr_n, addr_incr;
  instr_t instr_aligned;
  instr_t instr_unaligned;
  logic   word_valid;
  logic   unaligned_full_valid;
  logic   aligned_is_c;
  logic   unaligned_is_c;

  ////////////////////////////////////////
  // Output mux
  ////////////////////////////////////////

  // Current word, from entry 0 or straight from the bus
  assign instr_aligned = valid_q[0] ? rdata_q[0] : resp_rdata_i;

  // Upper half of current word joined with lower half of the next one
  assign instr_unaligned = valid_q[1] ? {rdata_q[1][15:0], instr_aligned[31:16]} :
                                        {resp_rdata_i[15:0], instr_aligned[31:16]};

  assign word_valid = valid_q[0] || resp_valid_i;
  // Straddler needs two words: both queued, or one queued plus bypass
  assign unaligned_full_valid = valid_q[1] || (valid_q[0] && resp_valid_i);

  // Compressed check on the low bits of the starting halfword
  assign aligned_is_c   = instr_aligned[1:0] != 2'b11;
  assign unaligned_is_c = instr_aligned[17:16] != 2'b11;

  always_comb begin
    instr_o       = instr_aligned;
    instr_valid_o = 1'b0;
    if (branch_i) begin
      // Current contents belong to the old path
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      instr_o       = instr_unaligned;
      instr_valid_o = unaligned_is_c ? word_valid : unaligned_full_valid;
    end else begin
      instr_valid_o = word_valid;
    end
  end

  assign instr_pop_o  = instr_valid_o && instr_ready_i;
  assign instr_addr_o = addr_q;

  ////////////////////////////////////////
  // Queue write and advance
  ////////////////////////////////////////

  // Incoming word goes to the first free slot
  always_comb begin
    rdata_int = rdata_q;
    valid_int = valid_q;
    if (resp_valid_i) begin
      for (int i = 0; i < FETCH_DEPTH; i++) begin
        if (!valid_q[i]) begin
          rdata_int[i] = resp_rdata_i;
          valid_int[i] = 1'b1;
          break;
        end
      end
    end
  end

  assign addr_incr = {addr_q[31:2], 2'b00} + 32'd4;

  always_comb begin
    logic shift;
    shift   = 1'b0;
    addr_n  = addr_q;
    rdata_n = rdata_int;
    valid_n = valid_int;
    if (instr_pop_o) begin
      if (addr_q[1]) begin
        // Leaving an upper half always finishes the current word
        addr_n = unaligned_is_c ? {addr_incr[31:2], 2'b00} : {addr_incr[31:2], 2'b10};
        shift  = 1'b1;
      end else if (aligned_is_c) begin
        // Upper half of the same word is next
        addr_n = {addr_q[31:2], 2'b10};
      end else begin
        addr_n = addr_incr;
        shift  = 1'b1;
      end
    end
    if (shift) begin
      for (int i = 0; i < FETCH_DEPTH - 1; i++) begin
        rdata_n[i] = rdata_int[i + 1];
      end
      valid_n = {valid_int[1:FETCH_DEPTH-1], 1'b0};
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      addr_q  <= '0;
    end else if (branch_i) begin
      // Flush queue, first returned instruction sits at the target
      valid_q <= '0;
      addr_q  <= branch_addr_i;
    end else begin
      valid_q <= valid_n;
      addr_q  <= addr_n;
    end
  end

  // Word storage, qualified by valid_q
  always_ff @(posedge clk) begin
    rdata_q <= rdata_n;
  end

endmodule

// ==== logic/fetch_top.sv ====
/*
 * Instruction fetch front end top level. Connects the fetch control,
 * request generator, instruction counter and alignment buffer between
 * the instruction memory port and the decode stage.
 */

module fetch_top (
  input  logic              clk,
  input  logic              rst_n,
  // Branch side
  input  logic              branch_i,
  input  fetch_pkg::addr_t  branch_addr_i,
  input  logic              prefetch_en_i,
  output logic              prefetch_busy_o,
  // Memory side
  output logic              mem_req_o,
  output fetch_pkg::addr_t  mem_addr_o,
  input  logic              mem_gnt_i,
  input  logic              mem_rvalid_i,
  input  fetch_pkg::instr_t mem_rdata_i,
  // Decode side
  output logic              instr_valid_o,
  input  logic              instr_ready_i,
  output fetch_pkg::instr_t instr_o,
  output fetch_pkg::addr_t  instr_addr_o
);

  import fetch_pkg::*;

  logic       fetch_valid;
  logic       resp_valid_gated;
  logic       instr_pop;
  instr_cnt_t instr_cnt;

  fetch_ctrl u_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .branch_i           (branch_i),
    .prefetch_en_i      (prefetch_en_i),
    .mem_gnt_i          (mem_gnt_i),
    .mem_rvalid_i       (mem_rvalid_i),
    .instr_cnt_i        (instr_cnt),
    .fetch_valid_o      (fetch_valid),
    .resp_valid_gated_o (resp_valid_gated),
    .prefetch_busy_o    (prefetch_busy_o)
  );

  fetch_req_gen u_req_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .fetch_valid_i (fetch_valid),
    .mem_gnt_i     (mem_gnt_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o)
  );

  // Counter and buffer only see words from the current path
  instr_count_track u_cnt (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .resp_valid_i  (resp_valid_gated),
    .resp_rdata_i  (mem_rdata_i),
    .instr_pop_i   (instr_pop),
    .instr_cnt_o   (instr_cnt)
  );

  instr_align_buf u_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .resp_valid_i  (resp_valid_gated),
    .resp_rdata_i  (mem_rdata_i),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .instr_pop_o   (instr_pop)
  );

endmodule

// ==== bench/fetch_mem_model.sv ====
/*
 * Instruction memory model for the fetch testbench. Grants requests
 * after 0 to 2 stall cycles and answers in order 1 to 3 cycles after
 * each grant. The bench supplies the image word and the random bits.
 */

module fetch_mem_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] word_i,
  input  logic [31:0] rand_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  // Pending responses, oldest first
  logic [31:0] data_q [$];
  int          due_q [$];
  int          cycle;
  int          last_due;
  int          stall_target;
  int          stall_cnt;
  int          latency;
  int          due;

  initial begin
    gnt_o        = 1'b0;
    rvalid_o     = 1'b0;
    rdata_o      = '0;
    cycle        = 0;
    last_due     = 0;
    stall_target = 0;
    stall_cnt    = 0;
    forever begin
      // Look at the cycle where request and grant are stable
      @(negedge clk);
      if (!rst_n) begin
        data_q.delete();
        due_q.delete();
        stall_cnt    = 0;
        stall_target = 0;
      end else if (req_i && gnt_o) begin
        latency = 1 + rand_i[5:4] % 3;
        // Keep answers in order, one per cycle at most
        due = (cycle + latency > last_due) ? cycle + latency : last_due + 1;
        last_due = due;
        data_q.push_back(word_i);
        due_q.push_back(due);
        stall_target = rand_i[1:0] % 3;
        stall_cnt    = 0;
      end else if (req_i) begin
        stall_cnt++;
      end
      @(posedge clk);
      #1;
      cycle++;
      gnt_o    = rst_n && (stall_cnt >= stall_target);
      rvalid_o = 1'b0;
      if (due_q.size() > 0 && due_q[0] == cycle) begin
        rvalid_o = 1'b1;
        rdata_o  = data_q.pop_front();
        due      = due_q.pop_front();
      end
    end
  end

endmodule

// ==== bench/fetch_tb.sv ====
/*
 * Testbench for the fetch front end. Builds a random image of mixed
 * 16-bit and 32-bit instructions, runs fetch through branches and
 * decode stalls, and checks every instruction taken by decode
 * against a halfword walk of the image.
 */

module fetch_tb;

  import fetch_pkg::*;

  localparam int IMAGE_WORDS = 256;
  localparam int WAIT_LIMIT  = 2000;

  logic        clk;
  logic        rst_n;
  logic        branch;
  addr_t       branch_addr;
  logic        prefetch_en;
  logic        prefetch_busy;
  logic        mem_req;
  addr_t       mem_addr;
  logic        mem_gnt;
  logic        mem_rvalid;
  instr_t      mem_rdata;
  logic        instr_valid;
  logic        instr_ready;
  instr_t      instr;
  addr_t       instr_addr;

  logic [31:0] image [0:IMAGE_WORDS-1];
  logic [31:0] mem_word;
  logic [31:0] mem_rand;
  logic [31:0] rnd;
  logic        hold_ready;
  logic        fetch_started;
  logic        timed_out;
  int          mismatches;
  int          failures;
  int          accepted_cnt;
  int          in_flight;
  int          stale_left;
  addr_t       exp_word;
  addr_t       ref_addr;
  logic        prev_valid;
  logic        prev_ready;
  instr_t      prev_instr;
  addr_t       prev_addr;

  fetch_top u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch),
    .branch_addr_i   (branch_addr),
    .prefetch_en_i   (prefetch_en),
    .prefetch_busy_o (prefetch_busy),
    .mem_req_o       (mem_req),
    .mem_addr_o      (mem_addr),
    .mem_gnt_i       (mem_gnt),
    .mem_rvalid_i    (mem_rvalid),
    .mem_rdata_i     (mem_rdata),
    .instr_valid_o   (instr_valid),
    .instr_ready_i   (instr_ready),
    .instr_o         (instr),
    .instr_addr_o    (instr_addr)
  );

  // Image wraps every 1 KiB
  assign mem_word = image[mem_addr[9:2]];

  fetch_mem_model u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (mem_req),
    .word_i   (mem_word),
    .rand_i   (mem_rand),
    .gnt_o    (mem_gnt),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Compressed or 32-bit start, even odds
  function automatic logic [15:0] random_half(input logic [31:0] r);
    logic [15:0] h;
    h = r[15:0];
    if (r[20]) begin
      h[1:0] = 2'b11;
    end else if (h[1:0] == 2'b11) begin
      h[1:0] = 2'b01;
    end
    return h;
  endfunction

  function automatic logic [15:0] image_half(input addr_t a);
    logic [31:0] w;
    w = image[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    mismatches++;
    $display("MISMATCH t=%0t %s expected=%h got=%h", $time, name, exp, got);
  endtask

  task automatic count_failure(input string what);
    failures++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  task automatic wait_instrs(input int n);
    int target;
    int cycles;
    target = accepted_cnt + n;
    cycles = 0;
    while (!timed_out && accepted_cnt < target && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!timed_out && accepted_cnt < target) begin
      count_failure("decode received no further instructions within the wait limit");
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (!timed_out && in_flight != 0 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (!timed_out && in_flight != 0) begin
      count_failure("memory responses still missing after the wait limit");
      timed_out = 1'b1;
    end
  endtask

  task automatic send_branch(input addr_t target);
    @(posedge clk);
    #1;
    branch      = 1'b1;
    branch_addr = target;
    @(posedge clk);
    #1;
    branch = 1'b0;
  endtask

  ////////////////////////////////////////
  // Image and random drive
  ////////////////////////////////////////

  initial begin
    rnd      = 32'h9d46;
    mem_rand = '0;
    for (int i = 0; i < IMAGE_WORDS; i++) begin
      rnd = xorshift(rnd);
      image[i][15:0] = random_half(rnd);
      rnd = xorshift(rnd);
      image[i][31:16] = random_half(rnd);
    end
    forever begin
      @(posedge clk);
      #1;
      rnd         = xorshift(rnd);
      mem_rand    = rnd;
      // Decode ready most cycles unless a stall is forced
      instr_ready = !hold_ready && (rnd[10:8] != 3'b000);
    end
  end

  ////////////////////////////////////////
  // Checks, sampled mid-cycle
  ////////////////////////////////////////

  always @(negedge clk) begin : monitor
    logic [15:0] lo;
    logic [15:0] hi;
    logic        accept;
    if (!fetch_started) begin
      assert (!mem_req && !instr_valid && !prefetch_busy)
        else count_failure("fetch outputs active before prefetch was enabled");
    end
    if (rst_n) begin
      accept = mem_req && mem_gnt;
      // Word addresses step by four and restart at a branch target
      if (branch) begin
        exp_word = {branch_addr[31:2], 2'b00};
      end
      if (accept) begin
        assert (mem_addr == exp_word) else show_mismatch("mem_addr_o", exp_word, mem_addr);
        exp_word = exp_word + 32'd4;
      end
      in_flight = in_flight + int'(accept) - int'(mem_rvalid);
      assert (in_flight >= 0 && in_flight <= MAX_OUTSTANDING)
        else count_failure("requests in flight outside the range zero to two");
      // Old-path words come back first, decode sees nothing meanwhile
      if (stale_left > 0) begin
        assert (!instr_valid)
          else count_failure("a word fetched before the branch reached decode");
        if (mem_rvalid) begin
          stale_left--;
        end
      end
      // Offered instruction holds while decode stalls
      if (prev_valid && !prev_ready && !branch) begin
        assert (instr_valid) else count_failure("instr_valid_o dropped during a decode stall");
        assert (instr_addr == prev_addr)
          else show_mismatch("instr_addr_o", prev_addr, instr_addr);
        if (prev_instr[1:0] != 2'b11) begin
          assert (instr[15:0] == prev_instr[15:0])
            else show_mismatch("instr_o", prev_instr, instr);
        end else begin
          assert (instr == prev_instr) else show_mismatch("instr_o", prev_instr, instr);
        end
      end
      if (branch) begin
        assert (!instr_valid) else count_failure("instr_valid_o high in a branch cycle");
        ref_addr   = branch_addr;
        // Everything still owed except a request granted right now
        stale_left = in_flight - int'(accept);
      end else if (instr_valid && instr_ready) begin
        lo = image_half(ref_addr);
        hi = image_half(ref_addr + 32'd2);
        assert (instr_addr == ref_addr) else show_mismatch("instr_addr_o", ref_addr, instr_addr);
        if (lo[1:0] != 2'b11) begin
          // 16-bit instruction, upper half of instr_o is don't care
          assert (instr[15:0] == lo)
            else show_mismatch("instr_o", {16'h0, lo}, {16'h0, instr[15:0]});
          ref_addr = ref_addr + 32'd2;
        end else begin
          assert (instr == {hi, lo}) else show_mismatch("instr_o", {hi, lo}, instr);
          ref_addr = ref_addr + 32'd4;
        end
        accepted_cnt++;
      end
      prev_valid = instr_valid;
      prev_ready = instr_ready;
      prev_instr = instr;
      prev_addr  = instr_addr;
    end else begin
      prev_valid = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    branch        = 1'b0;
    branch_addr   = '0;
    prefetch_en   = 1'b0;
    instr_ready   = 1'b0;
    hold_ready    = 1'b0;
    fetch_started = 1'b0;
    timed_out     = 1'b0;
    mismatches    = 0;
    failures      = 0;
    accepted_cnt  = 0;
    in_flight     = 0;
    stale_left    = 0;
    exp_word      = '0;
    ref_addr      = '0;
    prev_valid    = 1'b0;
    prev_ready    = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle window with prefetch still off
    repeat (6) @(posedge clk);
    #1;
    fetch_started = 1'b1;
    prefetch_en   = 1'b1;
    wait_instrs(40);
    // Aligned then unaligned target, both with words in flight
    send_branch(32'h0000_0100);
    wait_instrs(30);
    send_branch(32'h0000_01f2);
    wait_instrs(30);
    @(posedge clk);
    hold_ready = 1'b1;
    repeat (12) @(posedge clk);
    hold_ready = 1'b0;
    wait_instrs(10);
    // Straddle across the image end, then two close branches
    send_branch(32'h0000_03fe);
    wait_instrs(20);
    send_branch(32'h0000_0036);
    send_branch(32'h0000_008a);
    wait_instrs(20);
    @(posedge clk);
    #1;
    prefetch_en = 1'b0;
    wait_idle();
    repeat (8) begin
      @(negedge clk);
      assert (!prefetch_busy && !mem_req)
        else count_failure("fetch busy or requesting after prefetch was disabled");
    end
    $display("Checked %0d instructions: %0d mismatches, %0d other errors",
             accepted_cnt, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== fetch_unit.f ====
logic/fetch_pkg.sv
logic/fetch_ctrl.sv
logic/fetch_req_gen.sv
logic/instr_count_track.sv
logic/instr_align_buf.sv
logic/fetch_top.sv
bench/fetch_mem_model.sv
bench/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - logic/fetch_pkg.sv
  - logic/fetch_ctrl.sv
  - logic/fetch_req_gen.sv
  - logic/instr_count_track.sv
  - logic/instr_align_buf.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - bench/fetch_mem_model.sv
      - bench/fetch_tb.sv
